//--- common/model_defines.svh
`ifndef MODEL_DEFINES_SVH
`define MODEL_DEFINES_SVH

// Frame geometry.
`define MODEL_CHANNELS 4
`define MODEL_STEPS 6

// Convolution layer.
`define MODEL_KERNEL 3
`define MODEL_POSITIONS 4
`define MODEL_FILTERS 4

// Fully connected layer.
`define MODEL_CLASSES 3

// Datapath widths.
`define MODEL_DATA_W 8
`define MODEL_CONV_W 20
`define MODEL_LOGIT_W 32

`endif

//--- common/model_pkg.sv
`default_nettype none
`include "model_defines.svh"

package model_pkg;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_CONV = 2'd1,
        ST_FC   = 2'd2,
        ST_DONE = 2'd3
    } state_e;

    typedef logic signed [`MODEL_DATA_W-1:0]  sample_t;
    typedef logic signed [`MODEL_DATA_W-1:0]  weight_t;
    typedef logic signed [`MODEL_CONV_W-1:0]  conv_t;
    typedef logic signed [`MODEL_LOGIT_W-1:0] logit_t;

    // Indexed [filter][tap step][channel].
    localparam weight_t CONV_WEIGHT
        [0:`MODEL_FILTERS-1][0:`MODEL_KERNEL-1][0:`MODEL_CHANNELS-1] = '{
        '{
            '{  12, -34,  56,   7},
            '{ -89,  23, -45,  67},
            '{  31,  -8,  90, -12}
        },
        '{
            '{ -27,  64,  -3,  18},
            '{  45, -71,  29,  -6},
            '{  88,  14, -52,  39}
        },
        '{
            '{   5, -19,  77, -40},
            '{ -63,  36,  11,  94},
            '{  -2, -85,  47,  21}
        },
        '{
            '{-128, 127, -16,  33},
            '{   9,  58, -97,   4},
            '{  72, -25,  15, -60}
        }
    };

    localparam weight_t CONV_BIAS [0:`MODEL_FILTERS-1] = '{17, -42, 8, 101};

    // Indexed [class][conv result], results in filter-major order.
    localparam weight_t FC_WEIGHT
        [0:`MODEL_CLASSES-1][0:`MODEL_FILTERS*`MODEL_POSITIONS-1] = '{
        '{  3,  -7,  12,  -1,  25,  -9,   4,  16,
          -11,   6, -20,   2,   9, -14,  30,  -5},
        '{ -8,  19,  -3,  27, -15,   1,  22,  -6,
           13, -24,   5,  18,  -2,  11, -17,   7},
        '{ 14,  -4, -26,   9,   6, -12,  -1,  21,
            8,  15, -19, -10,  24,   3,  -7, -13}
    };

    localparam weight_t FC_BIAS [0:`MODEL_CLASSES-1] = '{-50, 33, 90};

endpackage

`default_nettype wire

//--- source/model_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module model_sequencer (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_conv_done,
    input  logic i_fc_done,
    output logic o_conv_start,
    output logic o_fc_start,
    output logic o_finished
);

    model_pkg::state_e state;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= model_pkg::ST_IDLE;
            o_conv_start <= 1'b0;
            o_fc_start   <= 1'b0;
            o_finished   <= 1'b0;
        end else begin
            o_conv_start <= 1'b0; // Pulses by default.
            o_fc_start   <= 1'b0;
            o_finished   <= 1'b0;
            case (state)
                model_pkg::ST_IDLE: begin
                    if (i_start) begin
                        state        <= model_pkg::ST_CONV;
                        o_conv_start <= 1'b1;
                    end
                end
                model_pkg::ST_CONV: begin
                    if (i_conv_done) begin
                        state      <= model_pkg::ST_FC;
                        o_fc_start <= 1'b1;
                    end
                end
                model_pkg::ST_FC: begin
                    if (i_fc_done) begin
                        state      <= model_pkg::ST_DONE;
                        o_finished <= 1'b1;
                    end
                end
                default: state <= model_pkg::ST_IDLE; // Done lasts one cycle.
            endcase
        end
    end

    a_starts_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_conv_start && o_fc_start));

    a_finished_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_finished |=> !o_finished);

endmodule

`default_nettype wire

//--- conv/conv_engine.sv
`timescale 1ns/100ps
`default_nettype none
`include "model_defines.svh"

module conv_engine (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_start,
    input  model_pkg::sample_t i_data [0:`MODEL_CHANNELS*`MODEL_STEPS-1],
    output model_pkg::conv_t   o_conv [0:`MODEL_FILTERS*`MODEL_POSITIONS-1],
    output logic               o_done
);

    localparam int FRAME = `MODEL_CHANNELS * `MODEL_STEPS;
    localparam int TAPS  = `MODEL_KERNEL * `MODEL_CHANNELS;

    model_pkg::sample_t frame [0:FRAME-1];
    logic               busy;
    logic [1:0]         filt;
    logic [1:0]         pos;
    logic [3:0]         tap;
    logic [1:0]         step_k;
    logic [1:0]         chan;
    logic [4:0]         sample_idx;
    model_pkg::conv_t   acc;
    model_pkg::conv_t   product;
    model_pkg::conv_t   acc_next;

    // Tap order is step-major, channel inside.
    assign step_k = tap[3:2];
    assign chan   = tap[1:0];

    // Frame is channel-major.
    assign sample_idx = 5'(chan) * 5'(`MODEL_STEPS) + 5'(pos) + 5'(step_k);

    assign product  = frame[sample_idx] * model_pkg::CONV_WEIGHT[filt][step_k][chan];
    assign acc_next = ((tap == '0) ? model_pkg::conv_t'(model_pkg::CONV_BIAS[filt]) : acc)
                      + product;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy   <= 1'b0;
            o_done <= 1'b0;
            filt   <= '0;
            pos    <= '0;
            tap    <= '0;
            acc    <= '0;
            for (int i = 0; i < FRAME; i++) begin
                frame[i] <= '0;
            end
            for (int i = 0; i < `MODEL_FILTERS * `MODEL_POSITIONS; i++) begin
                o_conv[i] <= '0;
            end
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy <= 1'b1; // Frame freezes here.
                filt <= '0;
                pos  <= '0;
                tap  <= '0;
            end else if (busy) begin
                acc <= acc_next;
                if (tap == 4'(TAPS - 1)) begin
                    o_conv[{filt, pos}] <= acc_next;
                    tap <= '0;
                    pos <= pos + 2'd1;
                    if (pos == 2'(`MODEL_POSITIONS - 1)) begin
                        filt <= filt + 2'd1;
                        if (filt == 2'(`MODEL_FILTERS - 1)) begin
                            busy   <= 1'b0;
                            o_done <= 1'b1;
                        end
                    end
                end else begin
                    tap <= tap + 4'd1;
                end
            end else begin
                // Tracks the inputs while idle, so the frame seen with the
                // user's start is what the run uses.
                frame <= i_data;
            end
        end
    end

    a_no_restart: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_start |-> !busy);

    a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_done |=> !o_done);

endmodule

`default_nettype wire

//--- fc/fc_engine.sv
`timescale 1ns/100ps
`default_nettype none
`include "model_defines.svh"

module fc_engine (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_start,
    input  model_pkg::conv_t  i_conv [0:`MODEL_FILTERS*`MODEL_POSITIONS-1],
    output model_pkg::logit_t o_logits [0:`MODEL_CLASSES-1],
    output logic              o_done
);

    localparam int INPUTS = `MODEL_FILTERS * `MODEL_POSITIONS;

    logic              busy;
    logic [1:0]        cls;
    logic [3:0]        idx;
    model_pkg::logit_t acc;
    model_pkg::logit_t product;
    model_pkg::logit_t acc_next;

    // Operands widen to 32 bits before the multiply.
    assign product  = i_conv[idx] * model_pkg::FC_WEIGHT[cls][idx];
    assign acc_next = ((idx == '0) ? model_pkg::logit_t'(model_pkg::FC_BIAS[cls]) : acc)
                      + product;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy   <= 1'b0;
            o_done <= 1'b0;
            cls    <= '0;
            idx    <= '0;
            acc    <= '0;
            for (int i = 0; i < `MODEL_CLASSES; i++) begin
                o_logits[i] <= '0;
            end
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy <= 1'b1;
                cls  <= '0;
                idx  <= '0;
            end else if (busy) begin
                acc <= acc_next;
                idx <= idx + 4'd1; // Wraps to 0 after the last input.
                if (idx == 4'(INPUTS - 1)) begin
                    o_logits[cls] <= acc_next;
                    if (cls == 2'(`MODEL_CLASSES - 1)) begin
                        cls    <= '0;
                        busy   <= 1'b0;
                        o_done <= 1'b1;
                    end else begin
                        cls <= cls + 2'd1;
                    end
                end
            end
        end
    end

    // Conv results must stay stable for the whole pass.
    a_no_restart: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_start |-> !busy);

endmodule

`default_nettype wire

//--- source/model_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "model_defines.svh"

module model_top (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_start,
    input  model_pkg::sample_t i_data [0:`MODEL_CHANNELS*`MODEL_STEPS-1],
    output model_pkg::conv_t   o_conv [0:`MODEL_FILTERS*`MODEL_POSITIONS-1],
    output model_pkg::logit_t  o_logits [0:`MODEL_CLASSES-1],
    output logic               o_finished
);

    logic conv_start;
    logic conv_done;
    logic fc_start;
    logic fc_done;

    model_sequencer u_sequencer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_conv_done  (conv_done),
        .i_fc_done    (fc_done),
        .o_conv_start (conv_start),
        .o_fc_start   (fc_start),
        .o_finished   (o_finished)
    );

    // Frame is taken straight from the top-level inputs.
    conv_engine u_conv (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (conv_start),
        .i_data  (i_data),
        .o_conv  (o_conv),
        .o_done  (conv_done)
    );

    // Reads the held conv results in place.
    fc_engine u_fc (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (fc_start),
        .i_conv   (o_conv),
        .o_logits (o_logits),
        .o_done   (fc_done)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk
);

    localparam real HALF_PERIOD = 4.0; // 8 ns clock.

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

//--- dv/model_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "model_defines.svh"

module model_tb;

    localparam int ROWS         = 8;
    localparam int FRAME        = `MODEL_CHANNELS * `MODEL_STEPS;
    localparam int NCONV        = `MODEL_FILTERS * `MODEL_POSITIONS;
    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES   = 300;
    // Table rows, the ignored-start run and its quiet window.
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + RUN_CYCLES * (ROWS + 2) + 20;

    logic               clk;
    logic               rst_n;
    logic               start;
    model_pkg::sample_t data_in [0:FRAME-1];
    model_pkg::conv_t   conv_out [0:NCONV-1];
    model_pkg::logit_t  logits_out [0:`MODEL_CLASSES-1];
    logic               finished;

    model_pkg::sample_t frames [0:ROWS-1][0:FRAME-1];
    string              names [0:ROWS-1];
    int                 exp_conv [0:ROWS-1][0:NCONV-1];
    longint             exp_logit [0:ROWS-1][0:`MODEL_CLASSES-1];

    tb_clock_gen u_clock (.o_clk(clk));

    model_top DUT (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_start    (start),
        .i_data     (data_in),
        .o_conv     (conv_out),
        .o_logits   (logits_out),
        .o_finished (finished)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on error.");
    endtask

    task automatic build_table();
        void'($urandom(32'h44be7c96));
        names = '{"zeros", "all_ones", "all_max", "alternating", "ramp",
                  "random_0", "random_1", "random_2"};
        for (int i = 0; i < FRAME; i++) begin
            frames[0][i] = 8'sd0;
            frames[1][i] = 8'sd1;
            frames[2][i] = 8'sd127;
            frames[3][i] = (i % 2 == 0) ? 8'sd127 : -8'sd128;
            frames[4][i] = model_pkg::sample_t'(i * 10 - 115);
            for (int r = 5; r < ROWS; r++) begin
                frames[r][i] = model_pkg::sample_t'($urandom);
            end
        end
    endtask

    // Reference model from the convolution and fully connected rules.
    task automatic compute_expected(input int r);
        int     sample;
        int     weight;
        int     sum;
        longint lsum;
        for (int f = 0; f < `MODEL_FILTERS; f++) begin
            for (int p = 0; p < `MODEL_POSITIONS; p++) begin
                sum = int'(model_pkg::CONV_BIAS[f]);
                for (int k = 0; k < `MODEL_KERNEL; k++) begin
                    for (int c = 0; c < `MODEL_CHANNELS; c++) begin
                        sample = int'(frames[r][c * `MODEL_STEPS + p + k]);
                        weight = int'(model_pkg::CONV_WEIGHT[f][k][c]);
                        sum    = sum + sample * weight;
                    end
                end
                exp_conv[r][f * `MODEL_POSITIONS + p] = sum;
            end
        end
        for (int j = 0; j < `MODEL_CLASSES; j++) begin
            lsum = longint'(model_pkg::FC_BIAS[j]);
            for (int i = 0; i < NCONV; i++) begin
                lsum = lsum + longint'(exp_conv[r][i]) * longint'(model_pkg::FC_WEIGHT[j][i]);
            end
            exp_logit[r][j] = lsum;
        end
    endtask

    // Called on a rising edge; the start pulse lasts one cycle.
    task automatic start_run(input int r);
        for (int i = 0; i < FRAME; i++) begin
            data_in[i] <= frames[r][i];
        end
        start <= 1'b1;
        @(posedge clk);
        assert (!finished)
            else fail_run("o_finished stayed high for more than one cycle.");
        start <= 1'b0;
        for (int i = 0; i < FRAME; i++) begin
            data_in[i] <= ~frames[r][i]; // Only the start cycle carries the frame.
        end
    endtask

    task automatic wait_for_finished();
        do begin
            @(posedge clk);
        end while (!finished);
    endtask

    task automatic compare_results(input string name, input int r);
        for (int i = 0; i < NCONV; i++) begin
            assert (int'(conv_out[i]) == exp_conv[r][i])
                else fail_run($sformatf("MISMATCH test=%s o_conv[%0d] expected=%0d actual=%0d",
                                        name, i, exp_conv[r][i], conv_out[i]));
        end
        for (int j = 0; j < `MODEL_CLASSES; j++) begin
            assert (longint'(logits_out[j]) == exp_logit[r][j])
                else fail_run($sformatf("MISMATCH test=%s o_logits[%0d] expected=%0d actual=%0d",
                                        name, j, exp_logit[r][j], logits_out[j]));
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("Timeout: the run did not reach its end in the allowed time.");
    end

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        for (int i = 0; i < FRAME; i++) begin
            data_in[i] = '0;
        end
        build_table();
        for (int r = 0; r < ROWS; r++) begin
            compute_expected(r);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!finished) else fail_run("o_finished is high after reset.");
        for (int i = 0; i < NCONV; i++) begin
            assert (conv_out[i] == '0)
                else fail_run($sformatf("MISMATCH test=reset o_conv[%0d] expected=0 actual=%0d",
                                        i, conv_out[i]));
        end
        for (int j = 0; j < `MODEL_CLASSES; j++) begin
            assert (logits_out[j] == '0)
                else fail_run($sformatf("MISMATCH test=reset o_logits[%0d] expected=0 actual=%0d",
                                        j, logits_out[j]));
        end

        // Each next start follows o_finished directly.
        start_run(0);
        for (int r = 0; r < ROWS; r++) begin
            wait_for_finished();
            compare_results(names[r], r);
            if (r < ROWS - 1) begin
                start_run(r + 1);
            end
        end

        // A second start in the middle of a run carries other data.
        start_run(4);
        repeat (20) @(posedge clk);
        for (int i = 0; i < FRAME; i++) begin
            data_in[i] <= frames[2][i];
        end
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_for_finished();
        compare_results("ignored_start", 4);
        repeat (RUN_CYCLES) begin
            @(posedge clk);
            assert (!finished)
                else fail_run("A second o_finished pulse followed an ignored start.");
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- model_top.f
+incdir+common
common/model_pkg.sv
source/model_sequencer.sv
conv/conv_engine.sv
fc/fc_engine.sv
source/model_top.sv
dv/tb_clock_gen.sv
dv/model_tb.sv

//--- Bender.yml
package:
  name: model_top

export_include_dirs:
  - common

sources:
  - files:
      - common/model_pkg.sv
      - source/model_sequencer.sv
      - conv/conv_engine.sv
      - fc/fc_engine.sv
      - source/model_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/model_tb.sv
